// File: build.f
rtl/muldiv_pkg.sv
rtl/shift_add_multiplier.sv
rtl/restoring_divider.sv
rtl/result_arbiter.sv
rtl/result_bank.sv
rtl/muldiv_unit.sv
sim/tb_muldiv_unit.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run tb_muldiv_unit with Verilator, then look for the fail message in the log
set -o pipefail
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -f build.f --top-module tb_muldiv_unit -o tb_sim \
    && ./obj_dir/tb_sim | tee sim.log \
    || echo "TESTS FAILED" | tee -a sim.log

grep -q "TESTS FAILED" sim.log && exit 1 || exit 0

// File: sim/tb_muldiv_unit.sv
`timescale 1ns/1ps

module tb_muldiv_unit;
    import muldiv_pkg::*;

    localparam int SLOT_W     = 3;
    localparam int LAT        = 34;  // start edge to the edge that sees busy low
    localparam int OP_LIMIT   = 40;
    localparam int OP_CYCLES  = 40;
    localparam int MAX_CYCLES = OP_LIMIT * OP_CYCLES + 1400;

    typedef logic [SLOT_W-1:0] slot_t;

    logic     clk = 1'b0;
    logic     rst;
    logic     mul_start;
    operand_t mul_a;
    operand_t mul_b;
    slot_t    mul_tag;
    logic     mul_busy;
    logic     div_start;
    operand_t div_dividend;
    operand_t div_divisor;
    slot_t    div_tag;
    logic     div_busy;
    slot_t    rd_slot;
    result_t  rd_data;

    int          errors = 0;
    int          cycles = 0;
    logic [31:0] lfsr = 32'd24;
    result_t     exp_mem [2**SLOT_W];  // expected bank contents
    bit          last_mul;             // model of the arbiter's last grant
    int          mul_age;
    int          div_age;
    int          mul_lat = LAT;
    int          div_lat = LAT;
    logic        chk_en = 1'b0;
    result_t     exp_val;
    string       chk_name;
    string       test_name = "reset";

    muldiv_unit #(.SLOT_W(SLOT_W)) i_muldiv_unit (
        .clk(clk), .rst(rst),
        .mul_start(mul_start), .mul_a(mul_a), .mul_b(mul_b), .mul_tag(mul_tag),
        .mul_busy(mul_busy),
        .div_start(div_start), .div_dividend(div_dividend), .div_divisor(div_divisor),
        .div_tag(div_tag), .div_busy(div_busy),
        .rd_slot(rd_slot), .rd_data(rd_data)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles == MAX_CYCLES) begin
            $display("run did not finish within %0d cycles", MAX_CYCLES);
            $display("TESTS FAILED");
            $finish;
        end
    end

    // cycles since each unit took its start, zero when idle
    always @(posedge clk) begin
        if (rst) begin
            mul_age <= 0;
        end else if (mul_start && !mul_busy) begin
            mul_age <= 1;
        end else if (mul_age != 0 && !mul_busy) begin
            mul_age <= 0;
        end else if (mul_age != 0) begin
            mul_age <= mul_age + 1;
        end
    end

    always @(posedge clk) begin
        if (rst) begin
            div_age <= 0;
        end else if (div_start && !div_busy) begin
            div_age <= 1;
        end else if (div_age != 0 && !div_busy) begin
            div_age <= 0;
        end else if (div_age != 0) begin
            div_age <= div_age + 1;
        end
    end

    a_reset_idle: assert property (@(posedge clk) $fell(rst) |-> (!mul_busy && !div_busy))
        else begin
            errors++;
            $display("[ERROR] reset: busy pair expected 00 actual %b%b", mul_busy, div_busy);
        end

    a_mul_busy_held: assert property (@(posedge clk) disable iff (rst)
        (mul_age != 0 && mul_age < mul_lat) |-> mul_busy)
        else begin
            errors++;
            $display("[ERROR] %s: mul_busy expected 1 actual 0", test_name);
        end

    a_mul_busy_fall: assert property (@(posedge clk) disable iff (rst)
        (mul_age == mul_lat) |-> !mul_busy)
        else begin
            errors++;
            $display("[ERROR] %s: mul_busy expected 0 actual 1", test_name);
        end

    a_div_busy_held: assert property (@(posedge clk) disable iff (rst)
        (div_age != 0 && div_age < div_lat) |-> div_busy)
        else begin
            errors++;
            $display("[ERROR] %s: div_busy expected 1 actual 0", test_name);
        end

    a_div_busy_fall: assert property (@(posedge clk) disable iff (rst)
        (div_age == div_lat) |-> !div_busy)
        else begin
            errors++;
            $display("[ERROR] %s: div_busy expected 0 actual 1", test_name);
        end

    a_result: assert property (@(posedge clk) disable iff (rst) chk_en |-> (rd_data == exp_val))
        else begin
            errors++;
            $display("[ERROR] %s: slot %0d expected %h actual %h",
                     chk_name, rd_slot, exp_val, rd_data);
        end

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic result_t mul_ref(input operand_t a, input operand_t b);
        return {32'd0, a} * {32'd0, b};
    endfunction

    function automatic result_t div_ref(input operand_t dd, input operand_t dv);
        if (dv == 32'd0) begin
            return {dd, 32'hFFFF_FFFF};  // what the restoring loop leaves behind
        end
        return {dd % dv, dd / dv};
    endfunction

    task automatic rand_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int k = 0; k < n; k++) begin
            lfsr = lfsr_next(lfsr);
            v = {v[30:0], lfsr[0]};
        end
    endtask

    task automatic drive_mul(input operand_t a, input operand_t b, input slot_t tag);
        mul_a     = a;
        mul_b     = b;
        mul_tag   = tag;
        mul_start = 1'b1;
    endtask

    task automatic drive_div(input operand_t dd, input operand_t dv, input slot_t tag);
        div_dividend = dd;
        div_divisor  = dv;
        div_tag      = tag;
        div_start    = 1'b1;
    endtask

    task automatic wait_idle();
        @(negedge clk);
        while (mul_busy || div_busy) begin
            @(negedge clk);
        end
    endtask

    task automatic check_slot(input slot_t slot);
        @(negedge clk);
        rd_slot  = slot;
        exp_val  = exp_mem[slot];
        chk_name = test_name;
        chk_en   = 1'b1;
        @(negedge clk);
        chk_en = 1'b0;
    endtask

    // poke: a second start with other operands while busy, aimed at decoy
    task automatic run_mul(input string name, input operand_t a, input operand_t b,
                           input slot_t tag, input bit poke, input slot_t decoy);
        test_name = name;
        mul_lat   = LAT;
        @(negedge clk);
        drive_mul(a, b, tag);
        exp_mem[tag] = mul_ref(a, b);
        @(negedge clk);
        mul_start = 1'b0;
        if (poke) begin
            repeat (10) @(negedge clk);
            drive_mul(~a, b + 32'd1, decoy);
            @(negedge clk);
            mul_start = 1'b0;
        end
        wait_idle();
        last_mul = 1'b1;
        check_slot(tag);
        if (poke) begin
            check_slot(decoy);
        end
    endtask

    task automatic run_div(input string name, input operand_t dd, input operand_t dv,
                           input slot_t tag, input bit poke, input slot_t decoy);
        test_name = name;
        div_lat   = LAT;
        @(negedge clk);
        drive_div(dd, dv, tag);
        exp_mem[tag] = div_ref(dd, dv);
        @(negedge clk);
        div_start = 1'b0;
        if (poke) begin
            repeat (10) @(negedge clk);
            drive_div(dd ^ 32'h5A5A_5A5A, dv + 32'd3, decoy);
            @(negedge clk);
            div_start = 1'b0;
        end
        wait_idle();
        last_mul = 1'b0;
        check_slot(tag);
        if (poke) begin
            check_slot(decoy);
        end
    endtask

    // both start together; the unit not granted last writes first
    task automatic run_tie(input string name, input operand_t a, input operand_t b,
                           input slot_t mtag, input operand_t dd, input operand_t dv,
                           input slot_t dtag);
        bit mul_wins;
        mul_wins  = !last_mul;
        test_name = name;
        mul_lat   = mul_wins ? LAT : LAT + 1;
        div_lat   = mul_wins ? LAT + 1 : LAT;
        @(negedge clk);
        drive_mul(a, b, mtag);
        drive_div(dd, dv, dtag);
        exp_mem[mtag] = mul_ref(a, b);
        exp_mem[dtag] = div_ref(dd, dv);
        @(negedge clk);
        mul_start = 1'b0;
        div_start = 1'b0;
        wait_idle();
        last_mul = !mul_wins;  // the loser was granted last
        check_slot(mtag);
        check_slot(dtag);
    endtask

    initial begin
        operand_t    a;
        operand_t    b;
        operand_t    dd;
        operand_t    dv;
        logic [31:0] sh;

        rst          = 1'b1;
        mul_start    = 1'b0;
        mul_a        = '0;
        mul_b        = '0;
        mul_tag      = '0;
        div_start    = 1'b0;
        div_dividend = '0;
        div_divisor  = '0;
        div_tag      = '0;
        rd_slot      = '0;
        last_mul     = 1'b1;
        repeat (2) @(negedge clk);
        rst = 1'b0;

        // first tie after reset, divider should win
        rand_bits(32, a);
        rand_bits(32, b);
        rand_bits(32, dd);
        rand_bits(32, dv);
        rand_bits(5, sh);
        run_tie("tie_first", a, b, slot_t'(0), dd, dv >> sh, slot_t'(1));

        rand_bits(32, b);
        run_mul("mul_zero", 32'd0, b, slot_t'(2), 1'b0, '0);
        run_mul("mul_one", 32'd1, b, slot_t'(3), 1'b0, '0);
        run_mul("mul_ones", 32'hFFFF_FFFF, 32'hFFFF_FFFF, slot_t'(4), 1'b0, '0);
        for (int i = 0; i < 4; i++) begin
            rand_bits(32, a);
            rand_bits(32, b);
            run_mul("mul_random", a, b, slot_t'(i), 1'b0, '0);
        end

        run_div("div_small", 32'd1000, 32'hF000_0000, slot_t'(5), 1'b0, '0);
        rand_bits(32, dd);
        run_div("div_zero", dd, 32'd0, slot_t'(6), 1'b0, '0);
        for (int i = 0; i < 4; i++) begin
            rand_bits(32, dd);
            rand_bits(32, dv);
            rand_bits(5, sh);
            run_div("div_random", dd, dv >> sh, slot_t'(i + 4), 1'b0, '0);
        end

        // starts during busy must not touch the decoy slots
        rand_bits(32, a);
        rand_bits(32, b);
        run_mul("mul_busy", a, b, slot_t'(2), 1'b1, slot_t'(7));
        rand_bits(32, dd);
        rand_bits(32, dv);
        run_div("div_busy", dd, dv >> 4, slot_t'(3), 1'b1, slot_t'(4));

        // divider went last, so the multiplier takes this tie
        rand_bits(32, a);
        rand_bits(32, b);
        rand_bits(32, dd);
        rand_bits(32, dv);
        run_tie("tie_second", a, b, slot_t'(5), dd, dv >> 8, slot_t'(6));

        repeat (2) @(negedge clk);
        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

// File: rtl/muldiv_unit.sv
`timescale 1ns/1ps

module muldiv_unit #(
    parameter int SLOT_W = 3
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 mul_start,
    input  muldiv_pkg::operand_t mul_a,
    input  muldiv_pkg::operand_t mul_b,
    input  logic [SLOT_W-1:0]    mul_tag,
    output logic                 mul_busy,
    input  logic                 div_start,
    input  muldiv_pkg::operand_t div_dividend,
    input  muldiv_pkg::operand_t div_divisor,
    input  logic [SLOT_W-1:0]    div_tag,
    output logic                 div_busy,
    input  logic [SLOT_W-1:0]    rd_slot,
    output muldiv_pkg::result_t  rd_data
);
    import muldiv_pkg::*;

    logic              mul_req;
    logic              mul_grant;
    logic [SLOT_W-1:0] mul_slot;
    result_t           mul_data;
    logic              div_req;
    logic              div_grant;
    logic [SLOT_W-1:0] div_slot;
    result_t           div_data;
    logic              bank_we;
    logic [SLOT_W-1:0] bank_slot;
    result_t           bank_data;

    shift_add_multiplier #(.SLOT_W(SLOT_W)) i_mul (
        .clk(clk), .rst(rst), .start(mul_start), .a(mul_a), .b(mul_b), .tag(mul_tag),
        .busy(mul_busy), .wr_req(mul_req), .wr_grant(mul_grant),
        .wr_slot(mul_slot), .wr_data(mul_data)
    );

    restoring_divider #(.SLOT_W(SLOT_W)) i_div (
        .clk(clk), .rst(rst), .start(div_start), .dividend(div_dividend),
        .divisor(div_divisor), .tag(div_tag), .busy(div_busy), .wr_req(div_req),
        .wr_grant(div_grant), .wr_slot(div_slot), .wr_data(div_data)
    );

    result_arbiter #(.SLOT_W(SLOT_W)) i_arb (
        .clk(clk), .rst(rst),
        .mul_req(mul_req), .mul_slot(mul_slot), .mul_data(mul_data), .mul_grant(mul_grant),
        .div_req(div_req), .div_slot(div_slot), .div_data(div_data), .div_grant(div_grant),
        .bank_we(bank_we), .bank_slot(bank_slot), .bank_data(bank_data)
    );

    result_bank #(.SLOT_W(SLOT_W)) i_bank (
        .clk(clk), .we(bank_we), .wr_slot(bank_slot), .wr_data(bank_data),
        .rd_slot(rd_slot), .rd_data(rd_data)
    );

endmodule

// File: rtl/result_bank.sv
`timescale 1ns/1ps

module result_bank #(
    parameter int SLOT_W = 3
) (
    input  logic                clk,
    input  logic                we,
    input  logic [SLOT_W-1:0]   wr_slot,
    input  muldiv_pkg::result_t wr_data,
    input  logic [SLOT_W-1:0]   rd_slot,
    output muldiv_pkg::result_t rd_data
);
    import muldiv_pkg::*;

    localparam int DEPTH = 2 ** SLOT_W;

    result_t mem [DEPTH];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[wr_slot] <= wr_data;
        end
    end

    assign rd_data = mem[rd_slot];  // async read

endmodule

// File: rtl/result_arbiter.sv
`timescale 1ns/1ps

module result_arbiter #(
    parameter int SLOT_W = 3
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                mul_req,
    input  logic [SLOT_W-1:0]   mul_slot,
    input  muldiv_pkg::result_t mul_data,
    output logic                mul_grant,
    input  logic                div_req,
    input  logic [SLOT_W-1:0]   div_slot,
    input  muldiv_pkg::result_t div_data,
    output logic                div_grant,
    output logic                bank_we,
    output logic [SLOT_W-1:0]   bank_slot,
    output muldiv_pkg::result_t bank_data
);
    logic last_mul;  // last grant went to the multiplier

    // on a tie the unit that did not win last time goes first
    assign mul_grant = mul_req && (!div_req || !last_mul);
    assign div_grant = div_req && (!mul_req || last_mul);

    always_ff @(posedge clk) begin
        if (rst) begin
            last_mul <= 1'b1;  // divider wins the first tie
        end else if (mul_grant) begin
            last_mul <= 1'b1;
        end else if (div_grant) begin
            last_mul <= 1'b0;
        end
    end

    assign bank_we   = mul_grant || div_grant;
    assign bank_slot = div_grant ? div_slot : mul_slot;
    assign bank_data = div_grant ? div_data : mul_data;

    // the unit that loses a tie gets the port in the very next cycle
    a_tie_loser_next: assert property (
        @(posedge clk) disable iff (rst)
        (mul_req && div_req) |=>
            ((mul_grant == $past(div_grant)) && (div_grant == $past(mul_grant)))
    ) else $error("tie loser not granted in the next cycle");

endmodule

// File: rtl/restoring_divider.sv
`timescale 1ns/1ps

module restoring_divider #(
    parameter int SLOT_W = 3
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 start,
    input  muldiv_pkg::operand_t dividend,
    input  muldiv_pkg::operand_t divisor,
    input  logic [SLOT_W-1:0]    tag,
    output logic                 busy,
    output logic                 wr_req,
    input  logic                 wr_grant,
    output logic [SLOT_W-1:0]    wr_slot,
    output muldiv_pkg::result_t  wr_data
);
    import muldiv_pkg::*;

    unit_state_t state;
    iter_t       iter_left;
    operand_t    dvsr;
    operand_t    rem;
    operand_t    quo;      // dividend bits out at the top, quotient bits in at the bottom
    logic [32:0] partial;  // remainder with the next dividend bit shifted in
    logic [32:0] diff;
    logic        borrow;
    logic        take;

    assign take = start && (state == IDLE);

    assign partial          = {rem, quo[31]};
    assign {borrow, diff}   = {1'b0, partial} - {2'b00, dvsr};

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= IDLE;
            iter_left <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (take) begin
                        state     <= RUN;
                        iter_left <= ITER_COUNT;
                    end
                end
                RUN: begin
                    iter_left <= iter_left - iter_t'(1);
                    if (iter_left == iter_t'(1)) begin
                        state <= WAIT_GRANT;
                    end
                end
                WAIT_GRANT: begin
                    if (wr_grant) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            dvsr    <= divisor;
            rem     <= '0;
            quo     <= dividend;
            wr_slot <= tag;
        end else if (state == RUN) begin
            if (borrow) begin
                rem <= partial[31:0];  // restore
                quo <= {quo[30:0], 1'b0};
            end else begin
                rem <= diff[31:0];
                quo <= {quo[30:0], 1'b1};
            end
        end
    end

    assign busy    = (state != IDLE);
    assign wr_req  = (state == WAIT_GRANT);
    assign wr_data = {rem, quo};

    a_iter_range: assert property (
        @(posedge clk) disable iff (rst)
        iter_left <= ITER_COUNT
    ) else $error("divider iteration count out of range");

endmodule

// File: rtl/shift_add_multiplier.sv
`timescale 1ns/1ps

module shift_add_multiplier #(
    parameter int SLOT_W = 3
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 start,
    input  muldiv_pkg::operand_t a,
    input  muldiv_pkg::operand_t b,
    input  logic [SLOT_W-1:0]    tag,
    output logic                 busy,
    output logic                 wr_req,
    input  logic                 wr_grant,
    output logic [SLOT_W-1:0]    wr_slot,
    output muldiv_pkg::result_t  wr_data
);
    import muldiv_pkg::*;

    unit_state_t state;
    iter_t       iter_left;
    operand_t    mcand;
    result_t     acc;       // high half : low half
    logic [32:0] sum;       // carry : high half after the add
    logic [64:0] acc_next;  // carry, high half, low half before the shift
    logic        take;

    assign take = start && (state == IDLE);

    // add only when the current multiplier bit is set
    assign sum = {1'b0, acc[63:32]} + (acc[0] ? {1'b0, mcand} : 33'd0);
    assign acc_next = {sum, acc[31:0]};

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= IDLE;
            iter_left <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (take) begin
                        state     <= RUN;
                        iter_left <= ITER_COUNT;
                    end
                end
                RUN: begin
                    iter_left <= iter_left - iter_t'(1);
                    if (iter_left == iter_t'(1)) begin
                        state <= WAIT_GRANT;  // last bit done
                    end
                end
                WAIT_GRANT: begin
                    if (wr_grant) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            mcand   <= a;
            acc     <= {32'd0, b};
            wr_slot <= tag;
        end else if (state == RUN) begin
            acc <= acc_next[64:1];  // carry and sum shift right together
        end
    end

    assign busy    = (state != IDLE);
    assign wr_req  = (state == WAIT_GRANT);
    assign wr_data = acc;

    // a request only once every multiplier bit has been used
    a_req_in_wait: assert property (
        @(posedge clk) disable iff (rst)
        wr_req |-> (iter_left == '0)
    ) else $error("multiplier wr_req before the last iteration");

    // product and slot stay put while the bank is busy elsewhere
    a_req_held: assert property (
        @(posedge clk) disable iff (rst)
        (wr_req && !wr_grant) |=> (wr_req && $stable(wr_data) && $stable(wr_slot))
    ) else $error("multiplier dropped or changed a pending write");

endmodule

// File: rtl/muldiv_pkg.sv
package muldiv_pkg;

    typedef logic [31:0] operand_t;  // multiplicand, multiplier, dividend or divisor
    typedef logic [63:0] result_t;   // product, or remainder:quotient
    typedef logic [5:0]  iter_t;     // iterations left, 0 to 32

    typedef enum logic [1:0] {
        IDLE,
        RUN,
        WAIT_GRANT
    } unit_state_t;

    // one bit per cycle over a 32-bit operand
    localparam iter_t ITER_COUNT = 6'd32;

endpackage
